// File: lms_stage_pkg.sv
// Shared word types, memory request structs and constants of the LMS first stage; import with ::*
package lms_stage_pkg;

  // ------------------------------
  // Stage constants
  // ------------------------------
  localparam int TAPS = 6;
  localparam int DATA_AW = 7;
  localparam int TAP_AW = 4;
  localparam int BIAS_AW = 5;
  // Rows 12..15 of tap memory hold one error word per phase
  localparam logic [TAP_AW-1:0] ERR_ROW_BASE = 4'd12;
  localparam int MU_SHIFT = 8;
  // Read strobe to write-back, in cycles
  localparam int UPDATE_LAT = 5;
  localparam int BIAS_LAT = 4;

  // Sample, tap, bias and error values
  typedef logic signed [31:0] word_t;

  // One tap row, v0 sits in the low word
  typedef struct packed {
    word_t v5;
    word_t v4;
    word_t v3;
    word_t v2;
    word_t v1;
    word_t v0;
  } tap_lanes_t;

  // RAM view and per-tap view of the same tap-memory word
  typedef union packed {
    logic [TAPS*32-1:0] raw;
    tap_lanes_t         taps;
  } tap_row_u;

  // ------------------------------
  // Memory requests
  // ------------------------------
  typedef struct packed {
    logic               wr_vld;
    logic [DATA_AW-1:0] wr_address;
    logic               rd_vld;
    logic [DATA_AW-1:0] rd_address;
  } data_mem_req_t;

  typedef struct packed {
    logic              wr_vld;
    logic [TAP_AW-1:0] wr_address;
    logic              lane_vld;
    logic [2:0]        lane_sel;
    logic              rd_vld;
    logic [TAP_AW-1:0] rd_address;
  } tap_mem_req_t;

  typedef struct packed {
    logic               wr_vld;
    logic [BIAS_AW-1:0] wr_address;
    logic               rd_vld;
    logic [BIAS_AW-1:0] rd_address;
  } bias_mem_req_t;

  // ------------------------------
  // Sequencer side
  // ------------------------------
  typedef struct packed {
    logic               vld;
    logic [DATA_AW-1:0] addr;
    word_t              value;
  } sample_wr_t;

  typedef struct packed {
    logic       vld;
    logic [1:0] phase;
    word_t      value;
  } error_wr_t;

  typedef struct packed {
    logic               active_normal;
    logic               start;
    logic [DATA_AW-1:0] data_addr;
    logic [TAP_AW-1:0]  tap_addr;
    logic               update_first;
    logic               update_latch;
    logic [1:0]         phase_read;
    logic [BIAS_AW-1:0] bias_wr_addr;
  } filter_cmd_t;

endpackage

// File: stage_ram.sv
// Dual-port RAM with one-cycle registered read and optional lane write; holds samples, taps and bias
`timescale 1ns/10ps

module stage_ram #(
  parameter int WIDTH  = 32,
  parameter int DEPTH  = 128,
  parameter int LANE_W = 32
) (
  input  logic                     clk,
  input  logic                     wr_vld,
  input  logic [$clog2(DEPTH)-1:0] wr_address,
  input  logic [WIDTH-1:0]         wr_data,
  input  logic                     lane_vld,
  input  logic [2:0]               lane_sel,
  input  logic                     rd_vld,
  input  logic [$clog2(DEPTH)-1:0] rd_address,
  output logic [WIDTH-1:0]         rd_data
);

  localparam int LANES = WIDTH / LANE_W;

  logic [WIDTH-1:0] mem [DEPTH];

  // Full word wins; a lane write takes its value from the low lane of wr_data
  always_ff @(posedge clk) begin
    if (wr_vld) begin
      mem[wr_address] <= wr_data;
    end else if (lane_vld) begin
      mem[wr_address][lane_sel*LANE_W +: LANE_W] <= wr_data[LANE_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld) begin
      rd_data <= mem[rd_address];
    end
  end

  lane_in_range : assert property (@(posedge clk) lane_vld |-> (int'(lane_sel) < LANES))
    else $error("Lane write outside the word, lane_sel %0d", lane_sel);

endmodule

// File: stage_mem_ctrl.sv
// Stage control; turns sequencer and error strobes into memory requests and times the write-back
`timescale 1ns/10ps

module stage_mem_ctrl
  import lms_stage_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  filter_cmd_t   cmd,
  input  sample_wr_t    sample_wr,
  input  error_wr_t     error_wr,
  output data_mem_req_t data_req,
  output tap_mem_req_t  tap_req,
  output bias_mem_req_t bias_req,
  output word_t         data_wr_data,
  output word_t         lane_wr_data,
  output logic          upd_first,
  output logic          upd_vld,
  output logic          out_vld_in,
  output logic          out_first_in
);

  logic [TAP_AW-1:0] tap_rd_addr;
  logic [TAP_AW-1:0] err_wr_row;
  logic              upd_strobe;

  // Registered part of the strobe line
  logic [UPDATE_LAT:1] upd_q;
  // Full strobe line, entry k is the update read strobe k cycles ago
  logic [UPDATE_LAT:0] upd_line;
  // Row addresses travelling with the strobe
  logic [TAP_AW-1:0]   addr_line [1:UPDATE_LAT];

  // ------------------------------
  // Sample memory
  // ------------------------------
  always_comb begin
    data_req.wr_vld     = sample_wr.vld;
    data_req.wr_address = sample_wr.addr;
    data_req.rd_vld     = cmd.active_normal;
    data_req.rd_address = cmd.data_addr;
  end

  assign data_wr_data = sample_wr.value;

  // ------------------------------
  // Tap memory
  // ------------------------------
  // Error row of the read phase on the first update read, tap row otherwise
  assign tap_rd_addr = cmd.update_first ? ERR_ROW_BASE + {2'b00, cmd.phase_read}
                                        : cmd.tap_addr;
  assign err_wr_row  = ERR_ROW_BASE + {2'b00, error_wr.phase};

  // Rows read here are written back after the update pipeline
  assign upd_strobe = cmd.update_latch & ~cmd.update_first;
  assign upd_line   = {upd_q, upd_strobe};

  always_ff @(posedge clk) begin
    if (reset) begin
      upd_q <= '0;
      for (int k = 1; k <= UPDATE_LAT; k++) begin
        addr_line[k] <= '0;
      end
    end else begin
      upd_q        <= upd_line[UPDATE_LAT-1:0];
      addr_line[1] <= tap_rd_addr;
      for (int k = 2; k <= UPDATE_LAT; k++) begin
        addr_line[k] <= addr_line[k-1];
      end
    end
  end

  always_comb begin
    tap_req.rd_vld     = cmd.active_normal;
    tap_req.rd_address = tap_rd_addr;
    // Write-back owns the address; the RAM then ignores the lane strobe
    tap_req.wr_vld     = upd_line[UPDATE_LAT];
    tap_req.wr_address = upd_line[UPDATE_LAT] ? addr_line[UPDATE_LAT] : err_wr_row;
    tap_req.lane_vld   = error_wr.vld;
    tap_req.lane_sel   = 3'd0;
  end

  assign lane_wr_data = error_wr.value;

  // ------------------------------
  // Bias memory
  // ------------------------------
  always_comb begin
    bias_req.rd_vld     = cmd.active_normal;
    bias_req.rd_address = BIAS_AW'(cmd.tap_addr);
    bias_req.wr_vld     = upd_line[BIAS_LAT];
    // Address taken live from the sequencer at write time
    bias_req.wr_address = cmd.bias_wr_addr;
  end

  // Flags lined up with the RAM read data
  always_ff @(posedge clk) begin
    if (reset) begin
      upd_first    <= 1'b0;
      out_vld_in   <= 1'b0;
      out_first_in <= 1'b0;
    end else begin
      upd_first    <= cmd.active_normal & cmd.update_first;
      out_vld_in   <= cmd.active_normal;
      out_first_in <= cmd.active_normal & cmd.start;
    end
  end

  assign upd_vld = upd_line[1];

  // Sequencer must keep error writes clear of write-back slots
  wb_err_overlap : assert property (@(posedge clk) disable iff (reset)
      !(upd_line[UPDATE_LAT] && error_wr.vld))
    else $error("Tap write-back and error write in the same cycle");

endmodule

// File: tap_update.sv
// LMS update of one tap row and its bias; four-stage pipeline feeding the stage-control write-back
`timescale 1ns/10ps

module tap_update
  import lms_stage_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     upd_first,
  input  logic     upd_vld,
  input  tap_row_u tap_rd,
  input  word_t    bias_rd,
  input  tap_row_u window,
  output tap_row_u tap_wr,
  output word_t    bias_wr
);

  word_t err_q;
  // Occupancy of shift, add and staging stages
  logic [3:1] vld_q;

  // Product stage
  word_t    prod_q [TAPS];
  tap_row_u old1_q;
  word_t    bias1_q;
  word_t    err1_q;
  // Shift stage
  word_t    sh_q [TAPS];
  tap_row_u old2_q;
  word_t    bias2_q;
  word_t    err_sh_q;
  // Add stage
  tap_row_u sum_q;
  word_t    bias_sum_q;
  // Output staging
  tap_row_u stage_q;

  // Error row comes back in lane v0 one cycle after the first read
  always_ff @(posedge clk) begin
    if (upd_first) begin
      err_q <= tap_rd.taps.v0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:1], upd_vld};
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (upd_vld) begin
      for (int k = 0; k < TAPS; k++) begin
        prod_q[k] <= err_q * word_t'(window.raw[k*32 +: 32]);
      end
      old1_q  <= tap_rd;
      bias1_q <= bias_rd;
      err1_q  <= err_q;
    end
    if (vld_q[1]) begin
      for (int k = 0; k < TAPS; k++) begin
        sh_q[k] <= prod_q[k] >>> MU_SHIFT;
      end
      old2_q   <= old1_q;
      bias2_q  <= bias1_q;
      err_sh_q <= err1_q >>> MU_SHIFT;
    end
    if (vld_q[2]) begin
      for (int k = 0; k < TAPS; k++) begin
        sum_q.raw[k*32 +: 32] <= word_t'(old2_q.raw[k*32 +: 32]) + sh_q[k];
      end
      bias_sum_q <= bias2_q + err_sh_q;
    end
    if (vld_q[3]) begin
      stage_q <= sum_q;
    end
  end

  // Bias leaves from the add stage, one cycle ahead of the taps
  assign bias_wr = bias_sum_q;
  assign tap_wr  = stage_q;

endmodule

// File: fir_datapath.sv
// Six-tap multiply-accumulate plus bias over a sliding sample window; drives the stage output
`timescale 1ns/10ps

module fir_datapath
  import lms_stage_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    sample_rd,
  input  tap_row_u tap_rd,
  input  word_t    bias_rd,
  input  logic     out_vld_in,
  input  logic     out_first_in,
  output tap_row_u window,
  output word_t    y,
  output logic     y_vld,
  output logic     y_first
);

  // Five older samples, most recent in the low word
  logic [(TAPS-1)*32-1:0] hist_q;
  word_t                  prod_q [TAPS];
  word_t                  bias_q;
  logic                   vld_q;
  logic                   first_q;
  word_t                  acc;

  // ------------------------------
  // Sample window
  // ------------------------------
  // Lane k holds the sample read k cycles back, v0 is the one just read
  assign window.raw = {hist_q, sample_rd};

  always_ff @(posedge clk) begin
    if (out_vld_in) begin
      hist_q <= {hist_q[(TAPS-2)*32-1:0], sample_rd};
    end
  end

  // ------------------------------
  // Multiply and sum
  // ------------------------------
  // Products keep the low 32 bits
  always_ff @(posedge clk) begin
    for (int k = 0; k < TAPS; k++) begin
      prod_q[k] <= word_t'(tap_rd.raw[k*32 +: 32]) * word_t'(window.raw[k*32 +: 32]);
    end
    bias_q <= bias_rd;
  end

  always_comb begin
    acc = bias_q;
    for (int k = 0; k < TAPS; k++) begin
      acc = acc + prod_q[k];
    end
  end

  always_ff @(posedge clk) begin
    y <= acc;
  end

  // Flags follow the two datapath stages
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q   <= 1'b0;
      first_q <= 1'b0;
      y_vld   <= 1'b0;
      y_first <= 1'b0;
    end else begin
      vld_q   <= out_vld_in;
      first_q <= out_first_in;
      y_vld   <= vld_q;
      y_first <= first_q;
    end
  end

endmodule

// File: lms_stage_top.sv
// Top of the LMS first stage; three memories, stage control, tap update and the filter datapath
`timescale 1ns/10ps

module lms_stage_top
  import lms_stage_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  sample_wr_t  sample_wr,
  input  error_wr_t   error_wr,
  input  filter_cmd_t cmd,
  output word_t       y,
  output logic        y_vld,
  output logic        y_first
);

  data_mem_req_t      data_req;
  tap_mem_req_t       tap_req;
  bias_mem_req_t      bias_req;
  word_t              data_wr_data;
  word_t              lane_wr_data;
  word_t              sample_rd;
  tap_row_u           tap_rd;
  word_t              bias_rd;
  tap_row_u           tap_wr;
  word_t              bias_wr;
  tap_row_u           window;
  logic [TAPS*32-1:0] tap_wr_word;
  logic               upd_first;
  logic               upd_vld;
  logic               out_vld_in;
  logic               out_first_in;

  // Whole updated row, or the error word in lane 0
  assign tap_wr_word = tap_req.wr_vld ? tap_wr.raw : {{((TAPS-1)*32){1'b0}}, lane_wr_data};

  // ------------------------------
  // Memories
  // ------------------------------
  stage_ram #(.WIDTH(32), .DEPTH(1 << DATA_AW), .LANE_W(32)) sample_ram_i (
    .clk        (clk),
    .wr_vld     (data_req.wr_vld),
    .wr_address (data_req.wr_address),
    .wr_data    (data_wr_data),
    .lane_vld   (1'b0),
    .lane_sel   (3'd0),
    .rd_vld     (data_req.rd_vld),
    .rd_address (data_req.rd_address),
    .rd_data    (sample_rd)
  );

  stage_ram #(.WIDTH(TAPS*32), .DEPTH(1 << TAP_AW), .LANE_W(32)) tap_ram_i (
    .clk        (clk),
    .wr_vld     (tap_req.wr_vld),
    .wr_address (tap_req.wr_address),
    .wr_data    (tap_wr_word),
    .lane_vld   (tap_req.lane_vld),
    .lane_sel   (tap_req.lane_sel),
    .rd_vld     (tap_req.rd_vld),
    .rd_address (tap_req.rd_address),
    .rd_data    (tap_rd)
  );

  stage_ram #(.WIDTH(32), .DEPTH(1 << BIAS_AW), .LANE_W(32)) bias_ram_i (
    .clk        (clk),
    .wr_vld     (bias_req.wr_vld),
    .wr_address (bias_req.wr_address),
    .wr_data    (bias_wr),
    .lane_vld   (1'b0),
    .lane_sel   (3'd0),
    .rd_vld     (bias_req.rd_vld),
    .rd_address (bias_req.rd_address),
    .rd_data    (bias_rd)
  );

  // ------------------------------
  // Control and datapaths
  // ------------------------------
  stage_mem_ctrl stage_mem_ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .sample_wr    (sample_wr),
    .error_wr     (error_wr),
    .data_req     (data_req),
    .tap_req      (tap_req),
    .bias_req     (bias_req),
    .data_wr_data (data_wr_data),
    .lane_wr_data (lane_wr_data),
    .upd_first    (upd_first),
    .upd_vld      (upd_vld),
    .out_vld_in   (out_vld_in),
    .out_first_in (out_first_in)
  );

  tap_update tap_update_i (
    .clk       (clk),
    .reset     (reset),
    .upd_first (upd_first),
    .upd_vld   (upd_vld),
    .tap_rd    (tap_rd),
    .bias_rd   (bias_rd),
    .window    (window),
    .tap_wr    (tap_wr),
    .bias_wr   (bias_wr)
  );

  fir_datapath fir_datapath_i (
    .clk          (clk),
    .reset        (reset),
    .sample_rd    (sample_rd),
    .tap_rd       (tap_rd),
    .bias_rd      (bias_rd),
    .out_vld_in   (out_vld_in),
    .out_first_in (out_first_in),
    .window       (window),
    .y            (y),
    .y_vld        (y_vld),
    .y_first      (y_first)
  );

endmodule

// File: tb_lms_stage.sv
// Self-checking testbench for lms_stage_top; run as top with a memory model and LCG stimulus
`timescale 1ns/10ps

module tb_lms_stage
  import lms_stage_pkg::*;
;

  localparam int ROWS         = 12;
  localparam int FILTER_LEN   = 20;
  localparam int ROUNDS       = 5;
  // Error write, gap, update pass with drain, filter pass with drain
  localparam int ROUND_CYCLES = 1 + 1 + (1 + ROWS + 8) + (FILTER_LEN + 4);
  localparam int TEST_CYCLES  = 16 + 4 + (1 << DATA_AW) + ROUNDS * ROUND_CYCLES + 8;
  localparam int CYCLE_LIMIT  = TEST_CYCLES + 200;

  // Expected output of one cycle, tagged with the test that caused it
  typedef struct packed {
    logic [1:0] tid;
    logic       vld;
    logic       first;
    word_t      y;
  } exp_t;

  logic        clk;
  logic        reset;
  sample_wr_t  sample_wr;
  error_wr_t   error_wr;
  filter_cmd_t cmd;
  word_t       y;
  logic        y_vld;
  logic        y_first;

  // Model of the three memories, the window and the captured error
  tap_row_u mt [1 << TAP_AW];
  word_t    mb [1 << BIAS_AW];
  word_t    ms [1 << DATA_AW];
  word_t    win [TAPS];
  word_t    err_m;

  logic [BIAS_AW-1:0] bias_sched [0:BIAS_LAT];
  exp_t               exp_in;
  exp_t               exp_line [1:3];
  logic [31:0]        rnd;
  int                 errors;
  int                 cycle_cnt;

  lms_stage_top lms_stage_top_i (
    .clk       (clk),
    .reset     (reset),
    .sample_wr (sample_wr),
    .error_wr  (error_wr),
    .cmd       (cmd),
    .y         (y),
    .y_vld     (y_vld),
    .y_first   (y_first)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string test_label(input logic [1:0] tid);
    case (tid)
      2'd1:    return "update_pass";
      2'd2:    return "filter_pass";
      default: return "idle";
    endcase
  endfunction

  // ------------------------------
  // One clock of stimulus plus the model
  // ------------------------------
  task automatic step(input filter_cmd_t c, input sample_wr_t s, input error_wr_t e,
                      input logic [1:0] tid);
    exp_t               ex;
    logic [TAP_AW-1:0]  row;
    logic [BIAS_AW-1:0] bias_row;
    word_t              prod;
    word_t              old;
    @(posedge clk);
    // Bias write address trails the update read by BIAS_LAT cycles
    for (int k = BIAS_LAT; k > 0; k--) begin
      bias_sched[k] = bias_sched[k-1];
    end
    bias_sched[0] = (c.update_latch && !c.update_first) ? BIAS_AW'(c.tap_addr) : '0;
    c.bias_wr_addr = bias_sched[BIAS_LAT];
    cmd       <= c;
    sample_wr <= s;
    error_wr  <= e;

    ex = '0;
    ex.tid = tid;
    if (s.vld) begin
      ms[s.addr] = s.value;
    end
    if (e.vld) begin
      mt[ERR_ROW_BASE + TAP_AW'(e.phase)].taps.v0 = e.value;
    end
    if (c.active_normal) begin
      for (int k = TAPS - 1; k > 0; k--) begin
        win[k] = win[k-1];
      end
      win[0] = ms[c.data_addr];
      row = c.update_first ? ERR_ROW_BASE + TAP_AW'(c.phase_read) : c.tap_addr;
      bias_row = BIAS_AW'(c.tap_addr);
      ex.vld   = 1'b1;
      ex.first = c.start;
      ex.y     = mb[bias_row];
      for (int k = 0; k < TAPS; k++) begin
        ex.y = ex.y + word_t'(mt[row].raw[k*32 +: 32]) * win[k];
      end
      if (c.update_first) begin
        err_m = mt[row].taps.v0;
      end
      // New tap is old plus error times sample, scaled by the step size
      if (c.update_latch && !c.update_first) begin
        for (int k = 0; k < TAPS; k++) begin
          old  = word_t'(mt[row].raw[k*32 +: 32]);
          prod = err_m * win[k];
          mt[row].raw[k*32 +: 32] = old + (prod >>> MU_SHIFT);
        end
        mb[bias_row] = mb[bias_row] + (err_m >>> MU_SHIFT);
      end
    end
    exp_in <= ex;
  endtask

  task automatic idle_steps(input int n);
    repeat (n) step('0, '0, '0, 2'd0);
  endtask

  task automatic write_samples();
    sample_wr_t s;
    for (int a = 0; a < (1 << DATA_AW); a++) begin
      rnd     = lcg_next(rnd);
      s.vld   = 1'b1;
      s.addr  = DATA_AW'(a);
      s.value = rnd;
      step('0, s, '0, 2'd0);
    end
  endtask

  task automatic write_error(input logic [1:0] p);
    error_wr_t e;
    rnd     = lcg_next(rnd);
    e.vld   = 1'b1;
    e.phase = p;
    e.value = rnd;
    step('0, '0, e, 2'd0);
  endtask

  // Error read-back, then one row per cycle with random samples
  task automatic update_pass(input logic [1:0] p);
    filter_cmd_t c;
    c = '0;
    c.active_normal = 1'b1;
    c.update_first  = 1'b1;
    c.phase_read    = p;
    rnd             = lcg_next(rnd);
    c.data_addr     = rnd[DATA_AW-1:0];
    step(c, '0, '0, 2'd1);
    for (int r = 0; r < ROWS; r++) begin
      c.update_first = 1'b0;
      c.update_latch = 1'b1;
      c.tap_addr     = TAP_AW'(r);
      rnd            = lcg_next(rnd);
      c.data_addr    = rnd[DATA_AW-1:0];
      step(c, '0, '0, 2'd1);
    end
    idle_steps(8);
  endtask

  task automatic filter_pass();
    filter_cmd_t        c;
    logic [DATA_AW-1:0] base;
    rnd  = lcg_next(rnd);
    base = rnd[DATA_AW-1:0];
    for (int i = 0; i < FILTER_LEN; i++) begin
      c = '0;
      c.active_normal = 1'b1;
      c.start         = (i == 0);
      c.data_addr     = base + DATA_AW'(i);
      c.tap_addr      = TAP_AW'(i % ROWS);
      step(c, '0, '0, 2'd2);
    end
    idle_steps(4);
  endtask

  // ------------------------------
  // Expected output line
  // ------------------------------
  always @(posedge clk) begin
    if (reset) begin
      for (int k = 1; k <= 3; k++) begin
        exp_line[k] <= '0;
      end
    end else begin
      exp_line[1] <= exp_in;
      exp_line[2] <= exp_line[1];
      exp_line[3] <= exp_line[2];
    end
  end

  vld_check : assert property (@(posedge clk) disable iff (reset) y_vld == exp_line[3].vld)
    else begin
      errors++;
      $display("Mismatch %s y_vld: expected %0b, actual %0b",
               test_label($sampled(exp_line[3].tid)), $sampled(exp_line[3].vld),
               $sampled(y_vld));
    end

  first_check : assert property (@(posedge clk) disable iff (reset)
      y_first == exp_line[3].first)
    else begin
      errors++;
      $display("Mismatch %s y_first: expected %0b, actual %0b",
               test_label($sampled(exp_line[3].tid)), $sampled(exp_line[3].first),
               $sampled(y_first));
    end

  y_check : assert property (@(posedge clk) disable iff (reset)
      exp_line[3].vld |-> y == exp_line[3].y)
    else begin
      errors++;
      $display("Mismatch %s y: expected %0d, actual %0d",
               test_label($sampled(exp_line[3].tid)), $sampled(exp_line[3].y), $sampled(y));
    end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Timeout, run still going after %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    sample_wr = '0;
    error_wr  = '0;
    cmd       = '0;
    exp_in    = '0;
    errors    = 0;
    cycle_cnt = 0;
    rnd       = 32'h6d;
    err_m     = '0;
    // Memories power up cleared in the simulator
    foreach (mt[i]) mt[i] = '0;
    foreach (mb[i]) mb[i] = '0;
    foreach (ms[i]) ms[i] = '0;
    foreach (win[i]) win[i] = '0;
    foreach (bias_sched[i]) bias_sched[i] = '0;

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    idle_steps(4);
    write_samples();
    for (int r = 0; r < ROUNDS; r++) begin
      write_error(2'(r % 4));
      idle_steps(1);
      update_pass(2'(r % 4));
      filter_pass();
    end
    idle_steps(8);

    $display("Checks done, error count %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: list.f
lms_stage_pkg.sv
stage_ram.sv
stage_mem_ctrl.sv
tap_update.sv
fir_datapath.sv
lms_stage_top.sv
tb_lms_stage.sv

// File: Makefile
# Verilator build for the LMS first stage
VERILATOR ?= verilator
TOP       := tb_lms_stage
FILELIST  := list.f
FLAGS     := --timing --assert --x-assign 0 --x-initial 0
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
